/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check sim.log"
	@echo "  clean  remove build outputs and log"
	@echo "  help   this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_ads_ctrl -Mdir obj_dir -f ads_ctrl.f
	./obj_dir/Vtb_ads_ctrl > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Finished with no errors" sim.log; then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* ads_ctrl.f */
source/ads_dev_pkg.sv
source/ads_link_pkg.sv
source/ads_spi_master.sv
source/ads_frame_reader.sv
source/ads_sequencer.sv
source/ads_wb_regs.sv
source/ads_ctrl_top.sv
testbench/ads_slave_model.sv
testbench/tb_ads_ctrl.sv

/* source/ads_ctrl_top.sv */
`timescale 1ns/1ps

module ads_ctrl_top #(
	parameter int CLKS_PER_HALF_BIT = 4,
	parameter int POR_CYCLES        = 64,
	parameter int RST_CYCLES        = 16,
	parameter int CS_HOLD_CYCLES    = 8
) (
	input  logic        i_CLK,
	input  logic        i_RSTN,
	// wishbone classic slave
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic [2:0]  i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack,
	output logic        o_frame_valid,
	// ads1292 pins
	output logic        o_SPI_CLK,
	output logic        o_SPI_MOSI,
	input  logic        i_SPI_MISO,
	output logic        o_SPI_CSN,
	input  logic        i_ADS_DRDY,
	output logic        o_ADS_RESETN,
	output logic        o_ADS_START
);

	ads_link_pkg::spi_req_t  w_spi_req;
	ads_link_pkg::spi_req_t  w_frame_spi_req;
	ads_link_pkg::spi_rsp_t  w_spi_rsp;
	ads_link_pkg::host_cmd_t w_cmd;
	ads_link_pkg::frame_t    w_frame;
	logic                    w_done;
	logic                    w_init_done;
	logic                    w_streaming;
	logic                    w_stream_en;
	logic                    w_stream_idle;
	logic [7:0]              w_rreg_data;
	logic                    w_rreg_valid;

	ads_spi_master #(.CLKS_PER_HALF_BIT(CLKS_PER_HALF_BIT)) u_spi (
		.i_CLK, .i_RSTN,
		.i_req      (w_spi_req),
		.o_rsp      (w_spi_rsp),
		.o_spi_clk  (o_SPI_CLK),
		.o_spi_mosi (o_SPI_MOSI),
		.i_spi_miso (i_SPI_MISO)
	);

	ads_sequencer #(
		.POR_CYCLES     (POR_CYCLES),
		.RST_CYCLES     (RST_CYCLES),
		.CS_HOLD_CYCLES (CS_HOLD_CYCLES)
	) u_seq (
		.i_CLK, .i_RSTN,
		.i_cmd           (w_cmd),
		.o_done          (w_done),
		.o_init_done     (w_init_done),
		.o_streaming     (w_streaming),
		.o_start_pin     (o_ADS_START),
		.o_spi_csn       (o_SPI_CSN),
		.o_ads_resetn    (o_ADS_RESETN),
		.o_spi_req       (w_spi_req),
		.i_spi_rsp       (w_spi_rsp),
		.i_frame_spi_req (w_frame_spi_req),
		.o_stream_en     (w_stream_en),
		.i_stream_idle   (w_stream_idle),
		.o_rreg_data     (w_rreg_data),
		.o_rreg_valid    (w_rreg_valid)
	);

	ads_frame_reader u_frame (
		.i_CLK, .i_RSTN,
		.i_drdy_n      (i_ADS_DRDY),
		.i_stream_en   (w_stream_en),
		.o_spi_req     (w_frame_spi_req),
		.i_spi_rsp     (w_spi_rsp),
		.o_stream_idle (w_stream_idle),
		.o_frame       (w_frame),
		.o_frame_valid (o_frame_valid)
	);

	ads_wb_regs u_regs (
		.i_CLK, .i_RSTN,
		.i_wb_cyc, .i_wb_stb, .i_wb_we, .i_wb_adr, .i_wb_dat, .o_wb_dat, .o_wb_ack,
		.o_cmd         (w_cmd),
		.i_done        (w_done),
		.i_init_done   (w_init_done),
		.i_streaming   (w_streaming),
		.i_start_pin   (o_ADS_START),
		.i_frame       (w_frame),
		.i_frame_valid (o_frame_valid),
		.i_rreg_data   (w_rreg_data),
		.i_rreg_valid  (w_rreg_valid)
	);

endmodule

/* source/ads_dev_pkg.sv */
package ads_dev_pkg;

	// ==================================================================
	// device side, command bytes and register opcodes
	// ==================================================================

	// single byte commands, sent alone with cs low
	typedef enum logic [7:0] {
		cmd_wakeup  = 8'h02, // leave standby
		cmd_standby = 8'h04,
		cmd_reset   = 8'h06, // host RESET pulses the pin instead
		cmd_start   = 8'h08, // start/stop go to the START pin
		cmd_stop    = 8'h0a,
		cmd_rdatac  = 8'h10, // continuous read on every drdy
		cmd_sdatac  = 8'h11
	} ads_cmd_e;

	// top three bits of the first opcode byte, low five hold the address
	typedef enum logic [2:0] {
		op_rreg = 3'b001,
		op_wreg = 3'b010
	} ads_op_e;

	localparam int REG_ADDR_BITS = 5;
	localparam int FRAME_BYTES   = 9; // status word + ch1 + ch2, 3 bytes each

	// ==================================================================
	// host side, operation field and wishbone word map
	// ==================================================================

	typedef enum logic [2:0] {
		host_syscmd = 3'd1, // arg carries the command byte
		host_wreg   = 3'd2, // arg = reg address, data = value
		host_rreg   = 3'd3,
		host_rdatac = 3'd4,
		host_sdatac = 3'd5
	} host_op_e;

	typedef enum logic [2:0] {
		addr_op         = 3'd0, // write starts an operation
		addr_status     = 3'd1,
		addr_frame_stat = 3'd2,
		addr_frame_ch1  = 3'd3,
		addr_frame_ch2  = 3'd4,
		addr_rreg_data  = 3'd5
	} reg_addr_e;

endpackage

/* source/ads_frame_reader.sv */
`timescale 1ns/1ps

module ads_frame_reader (
	input  logic                   i_CLK,
	input  logic                   i_RSTN,
	input  logic                   i_drdy_n,
	input  logic                   i_stream_en,
	output ads_link_pkg::spi_req_t o_spi_req,
	input  ads_link_pkg::spi_rsp_t i_spi_rsp,
	output logic                   o_stream_idle,
	output ads_link_pkg::frame_t   o_frame,
	output logic                   o_frame_valid
);

	localparam int N     = ads_dev_pkg::FRAME_BYTES;
	localparam int CNT_W = $clog2(N + 1);
	localparam int FW    = $bits(ads_link_pkg::frame_t);

	logic [2:0]           r_drdy;     // 2 sync stages + edge history
	logic                 r_active;   // frame in progress
	logic [CNT_W-1:0]     r_req_cnt;  // dummy bytes issued
	logic [CNT_W-1:0]     r_rx_cnt;   // bytes captured
	logic                 r_frame_valid;
	ads_link_pkg::frame_t r_frame;
	logic                 w_drdy_fall;
	logic                 w_rx;

	assign w_drdy_fall = r_drdy[2] & ~r_drdy[1];
	assign w_rx        = r_active & i_spi_rsp.rx_valid;

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_drdy        <= 3'b111; // drdy idles high
			r_active      <= 1'b0;
			r_req_cnt     <= '0;
			r_rx_cnt      <= '0;
			r_frame_valid <= 1'b0;
		end else begin
			r_drdy        <= {r_drdy[1:0], i_drdy_n};
			r_frame_valid <= 1'b0;
			if (!r_active) begin
				// an edge seen mid-frame is simply dropped
				if (w_drdy_fall && i_stream_en) begin
					r_active  <= 1'b1;
					r_req_cnt <= '0;
					r_rx_cnt  <= '0;
				end
			end else begin
				if (o_spi_req.valid)
					r_req_cnt <= r_req_cnt + 1'b1;
				if (w_rx) begin
					r_rx_cnt <= r_rx_cnt + 1'b1;
					if (r_rx_cnt == CNT_W'(N - 1)) begin
						r_active      <= 1'b0;
						r_frame_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_rx)
			r_frame <= {r_frame[FW-9:0], i_spi_rsp.rx_data}; // oldest ends at the top
	end

	// dummy byte whenever the engine is free
	assign o_spi_req.valid = r_active && i_spi_rsp.ready && (r_req_cnt != CNT_W'(N));
	assign o_spi_req.data  = 8'h00;
	assign o_stream_idle   = ~r_active;
	assign o_frame         = r_frame;
	assign o_frame_valid   = r_frame_valid;

	a_byte_count: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(r_rx_cnt <= r_req_cnt) && (r_req_cnt <= CNT_W'(N)));

endmodule

/* source/ads_link_pkg.sv */
package ads_link_pkg;

	// one byte toward the spi engine, valid for a single cycle
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} spi_req_t;

	// engine status and the byte captured on miso
	typedef struct packed {
		logic       ready;    // low while a byte is on the wire
		logic       rx_valid; // one cycle, byte finished
		logic [7:0] rx_data;
	} spi_rsp_t;

	// operation from the wishbone side, held until done
	typedef struct packed {
		logic                  valid;
		ads_dev_pkg::host_op_e op;
		logic [7:0]            arg;  // command byte or register address
		logic [7:0]            data; // wreg value
	} host_cmd_t;

	// one rdatac frame, first byte on the wire lands in stat[23:16]
	typedef struct packed {
		logic [23:0] stat;
		logic [23:0] ch1;
		logic [23:0] ch2;
	} frame_t;

endpackage

/* source/ads_sequencer.sv */
`timescale 1ns/1ps

module ads_sequencer #(
	parameter int POR_CYCLES     = 64,
	parameter int RST_CYCLES     = 16,
	parameter int CS_HOLD_CYCLES = 8
) (
	input  logic                    i_CLK,
	input  logic                    i_RSTN,
	input  ads_link_pkg::host_cmd_t i_cmd,
	output logic                    o_done,
	output logic                    o_init_done,
	output logic                    o_streaming,
	output logic                    o_start_pin,
	output logic                    o_spi_csn,
	output logic                    o_ads_resetn,
	output ads_link_pkg::spi_req_t  o_spi_req,
	input  ads_link_pkg::spi_rsp_t  i_spi_rsp,
	input  ads_link_pkg::spi_req_t  i_frame_spi_req,
	output logic                    o_stream_en,
	input  logic                    i_stream_idle,
	output logic [7:0]              o_rreg_data,
	output logic                    o_rreg_valid
);

	localparam int AW = ads_dev_pkg::REG_ADDR_BITS;

	typedef enum logic [3:0] {
		st_por,       // power-on wait
		st_rst,       // reset pin low
		st_idle,
		st_send,      // hand next byte to the engine
		st_byte_wait,
		st_cs_hold,   // cs low a little after the last byte
		st_ack,       // lets the host drop valid
		st_stream,
		st_drain      // wait for the frame in flight
	} state_e;

	state_e      r_state;
	logic [31:0] r_cnt;      // shared wait counter
	logic [23:0] r_seq;      // bytes still to send, top byte first
	logic [1:0]  r_nbytes;
	logic        r_is_rreg;
	logic        r_to_stream;
	logic        r_done;
	logic        r_init_done;
	logic        r_streaming;
	logic        r_stream_en;
	logic        r_start;
	logic        r_csn;
	logic        r_resetn;
	logic [7:0]  r_rreg_data;
	logic        r_rreg_valid;

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state      <= st_por;
			r_cnt        <= '0;
			r_seq        <= '0;
			r_nbytes     <= '0;
			r_is_rreg    <= 1'b0;
			r_to_stream  <= 1'b0;
			r_done       <= 1'b0;
			r_init_done  <= 1'b0;
			r_streaming  <= 1'b0;
			r_stream_en  <= 1'b0;
			r_start      <= 1'b0;
			r_csn        <= 1'b1;
			r_resetn     <= 1'b1;
			r_rreg_data  <= '0;
			r_rreg_valid <= 1'b0;
		end else begin
			r_done       <= 1'b0;
			r_rreg_valid <= 1'b0;
			case (r_state)
				// ==========================================================
				// power-up: wait, pulse reset, then SDATAC
				// ==========================================================
				st_por: begin
					r_cnt <= r_cnt + 32'd1;
					if (r_cnt == 32'(POR_CYCLES - 1)) begin
						r_cnt    <= '0;
						r_resetn <= 1'b0;
						r_state  <= st_rst;
					end
				end
				st_rst: begin
					r_cnt <= r_cnt + 32'd1;
					if (r_cnt == 32'(RST_CYCLES - 1)) begin
						r_cnt    <= '0;
						r_resetn <= 1'b1;
						if (r_init_done) begin // host RESET, pin only
							r_done  <= 1'b1;
							r_state <= st_ack;
						end else begin
							r_seq    <= {ads_dev_pkg::cmd_sdatac, 16'h0000};
							r_nbytes <= 2'd1;
							r_csn    <= 1'b0;
							r_state  <= st_send;
						end
					end
				end
				// ==========================================================
				// host operations
				// ==========================================================
				st_idle: begin
					if (i_cmd.valid) begin
						r_is_rreg   <= (i_cmd.op == ads_dev_pkg::host_rreg);
						r_to_stream <= (i_cmd.op == ads_dev_pkg::host_rdatac);
						r_seq       <= {i_cmd.arg, 16'h0000};
						r_nbytes    <= 2'd1;
						r_csn       <= 1'b0;
						r_state     <= st_send;
						case (i_cmd.op)
							ads_dev_pkg::host_wreg: begin
								// opcode+addr, count 0, value
								r_seq    <= {ads_dev_pkg::op_wreg, i_cmd.arg[AW-1:0],
									8'h00, i_cmd.data};
								r_nbytes <= 2'd3;
							end
							ads_dev_pkg::host_rreg: begin
								r_seq    <= {ads_dev_pkg::op_rreg, i_cmd.arg[AW-1:0], 16'h0000};
								r_nbytes <= 2'd3; // third byte is dummy, reply comes back
							end
							ads_dev_pkg::host_rdatac:
								r_seq <= {ads_dev_pkg::cmd_rdatac, 16'h0000};
							ads_dev_pkg::host_sdatac: begin
								r_seq   <= {ads_dev_pkg::cmd_sdatac, 16'h0000};
								r_start <= 1'b0;
							end
							ads_dev_pkg::host_syscmd: begin
								if (i_cmd.arg == ads_dev_pkg::cmd_start ||
									i_cmd.arg == ads_dev_pkg::cmd_stop) begin
									r_start <= (i_cmd.arg == ads_dev_pkg::cmd_start);
									r_csn   <= 1'b1; // pin only, no spi
									r_done  <= 1'b1;
									r_state <= st_ack;
								end else if (i_cmd.arg == ads_dev_pkg::cmd_reset) begin
									r_csn    <= 1'b1;
									r_resetn <= 1'b0;
									r_cnt    <= '0;
									r_state  <= st_rst;
								end
							end
							default: begin // unknown op, just ack
								r_csn   <= 1'b1;
								r_done  <= 1'b1;
								r_state <= st_ack;
							end
						endcase
					end
				end
				st_send: begin
					if (i_spi_rsp.ready) begin
						r_seq    <= {r_seq[15:0], 8'h00};
						r_nbytes <= r_nbytes - 2'd1;
						r_state  <= st_byte_wait;
					end
				end
				st_byte_wait: begin
					if (i_spi_rsp.rx_valid) begin
						if (r_nbytes != 2'd0) begin
							r_state <= st_send;
						end else if (r_to_stream) begin
							r_streaming <= 1'b1; // cs stays low from here
							r_stream_en <= 1'b1;
							r_done      <= 1'b1;
							r_state     <= st_stream;
						end else begin
							r_rreg_data  <= i_spi_rsp.rx_data;
							r_rreg_valid <= r_is_rreg;
							r_state      <= st_cs_hold;
						end
					end
				end
				st_cs_hold: begin
					r_cnt <= r_cnt + 32'd1;
					if (r_cnt == 32'(CS_HOLD_CYCLES - 1)) begin
						r_cnt <= '0;
						r_csn <= 1'b1;
						if (r_init_done) begin
							r_done  <= 1'b1; // same cycle cs rises
							r_state <= st_ack;
						end else begin
							r_init_done <= 1'b1;
							r_state     <= st_idle;
						end
					end
				end
				st_ack:
					r_state <= st_idle;
				// ==========================================================
				// continuous read, frame reader owns the link
				// ==========================================================
				st_stream: begin
					if (i_cmd.valid && i_cmd.op == ads_dev_pkg::host_sdatac) begin
						r_stream_en <= 1'b0;
						r_state     <= st_drain;
					end
				end
				st_drain: begin
					if (i_stream_idle) begin
						r_streaming <= 1'b0;
						r_start     <= 1'b0;
						r_to_stream <= 1'b0;
						r_is_rreg   <= 1'b0;
						r_seq       <= {ads_dev_pkg::cmd_sdatac, 16'h0000};
						r_nbytes    <= 2'd1;
						r_state     <= st_send;
					end
				end
				default:
					r_state <= st_idle;
			endcase
		end
	end

	// link mux, frame reader while streaming
	always_comb begin
		if (r_streaming) begin
			o_spi_req = i_frame_spi_req;
		end else begin
			o_spi_req.valid = (r_state == st_send) && i_spi_rsp.ready;
			o_spi_req.data  = r_seq[23:16];
		end
	end

	assign o_done       = r_done;
	assign o_init_done  = r_init_done;
	assign o_streaming  = r_streaming;
	assign o_stream_en  = r_stream_en;
	assign o_start_pin  = r_start;
	assign o_spi_csn    = r_csn;
	assign o_ads_resetn = r_resetn;
	assign o_rreg_data  = r_rreg_data;
	assign o_rreg_valid = r_rreg_valid;

	a_csn_standby: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(r_state == st_idle && !r_streaming) |-> r_csn);

endmodule

/* source/ads_spi_master.sv */
`timescale 1ns/1ps

module ads_spi_master #(
	parameter int CLKS_PER_HALF_BIT = 4
) (
	input  logic                   i_CLK,
	input  logic                   i_RSTN,
	input  ads_link_pkg::spi_req_t i_req,
	output ads_link_pkg::spi_rsp_t o_rsp,
	output logic                   o_spi_clk,
	output logic                   o_spi_mosi,
	input  logic                   i_spi_miso
);

	localparam int DIV_W = $clog2(CLKS_PER_HALF_BIT) + 1;

	logic [DIV_W-1:0] r_div;      // half-bit divider
	logic [4:0]       r_edges;    // sclk edges left, 16 per byte
	logic [7:0]       r_tx;
	logic [7:0]       r_rx;
	logic             r_sclk;
	logic             r_mosi;
	logic             r_rx_valid;
	logic             w_start;
	logic             w_tick;

	assign w_start = i_req.valid && (r_edges == 5'd0);
	// end of a half bit while a byte is running
	assign w_tick  = (r_edges != 5'd0) && (r_div == DIV_W'(CLKS_PER_HALF_BIT - 1));

	// ==================================================================
	// mode 1, cpol 0 / cpha 1
	// leading (rising) edge shifts mosi, trailing (falling) samples miso
	// ==================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_div      <= '0;
			r_edges    <= '0;
			r_sclk     <= 1'b0; // idle low
			r_mosi     <= 1'b0;
			r_rx_valid <= 1'b0;
		end else begin
			r_rx_valid <= 1'b0;
			if (w_start) begin
				r_edges <= 5'd16;
				r_div   <= '0;
			end else if (w_tick) begin
				r_div   <= '0;
				r_edges <= r_edges - 5'd1;
				r_sclk  <= ~r_sclk;
				if (!r_sclk)
					r_mosi <= r_tx[7];      // msb first
				else if (r_edges == 5'd1)
					r_rx_valid <= 1'b1;     // last falling edge, byte complete
			end else if (r_edges != 5'd0) begin
				r_div <= r_div + 1'b1;
			end
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_start)
			r_tx <= i_req.data;
		else if (w_tick && !r_sclk)
			r_tx <= {r_tx[6:0], 1'b0};
		else if (w_tick && r_sclk)
			r_rx <= {r_rx[6:0], i_spi_miso};
	end

	assign o_rsp.ready    = (r_edges == 5'd0); // drops the cycle after valid
	assign o_rsp.rx_valid = r_rx_valid;
	assign o_rsp.rx_data  = r_rx;
	assign o_spi_clk      = r_sclk;
	assign o_spi_mosi     = r_mosi;

	// whoever owns the link must wait for ready
	a_valid_needs_ready: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_req.valid |-> o_rsp.ready);

endmodule

/* source/ads_wb_regs.sv */
`timescale 1ns/1ps

module ads_wb_regs (
	input  logic                    i_CLK,
	input  logic                    i_RSTN,
	input  logic                    i_wb_cyc,
	input  logic                    i_wb_stb,
	input  logic                    i_wb_we,
	input  logic [2:0]              i_wb_adr,
	input  logic [31:0]             i_wb_dat,
	output logic [31:0]             o_wb_dat,
	output logic                    o_wb_ack,
	output ads_link_pkg::host_cmd_t o_cmd,
	input  logic                    i_done,
	input  logic                    i_init_done,
	input  logic                    i_streaming,
	input  logic                    i_start_pin,
	input  ads_link_pkg::frame_t    i_frame,
	input  logic                    i_frame_valid,
	input  logic [7:0]              i_rreg_data,
	input  logic                    i_rreg_valid
);

	ads_link_pkg::host_cmd_t r_cmd;
	ads_link_pkg::frame_t    r_frame;   // last complete frame
	logic [7:0]              r_rreg_data;
	logic [15:0]             r_frame_cnt;
	logic [31:0]             r_rdata;
	logic                    r_ack;
	logic                    w_req;
	logic                    w_op_wr;

	assign w_req   = i_wb_cyc & i_wb_stb & ~r_ack;
	assign w_op_wr = w_req & i_wb_we & (i_wb_adr == ads_dev_pkg::addr_op);

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_cmd       <= '0;
			r_ack       <= 1'b0;
			r_frame_cnt <= '0;
		end else begin
			r_ack <= 1'b0;
			if (w_req && !w_op_wr)
				r_ack <= 1'b1; // reads and other writes, next cycle
			if (w_op_wr && !r_cmd.valid) begin
				r_cmd.valid <= 1'b1;
				r_cmd.op    <= ads_dev_pkg::host_op_e'(i_wb_dat[18:16]);
				r_cmd.arg   <= i_wb_dat[15:8];
				r_cmd.data  <= i_wb_dat[7:0];
			end
			if (i_done) begin // op write acks only here
				r_cmd.valid <= 1'b0;
				r_ack       <= 1'b1;
			end
			if (i_frame_valid)
				r_frame_cnt <= r_frame_cnt + 16'd1; // wraps
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_req && !i_wb_we) begin
			case (i_wb_adr)
				ads_dev_pkg::addr_op:
					r_rdata <= {13'd0, r_cmd.op, r_cmd.arg, r_cmd.data};
				ads_dev_pkg::addr_status:
					r_rdata <= {i_init_done, i_streaming, i_start_pin, 13'd0, r_frame_cnt};
				ads_dev_pkg::addr_frame_stat: r_rdata <= {8'h00, r_frame.stat};
				ads_dev_pkg::addr_frame_ch1:  r_rdata <= {8'h00, r_frame.ch1};
				ads_dev_pkg::addr_frame_ch2:  r_rdata <= {8'h00, r_frame.ch2};
				ads_dev_pkg::addr_rreg_data:  r_rdata <= {24'h0, r_rreg_data};
				default:                      r_rdata <= '0;
			endcase
		end
		if (i_frame_valid)
			r_frame <= i_frame;
		if (i_rreg_valid)
			r_rreg_data <= i_rreg_data;
	end

	assign o_cmd    = r_cmd;
	assign o_wb_dat = r_rdata;
	assign o_wb_ack = r_ack;

endmodule

/* testbench/ads_slave_model.sv */
`timescale 1ns/1ps

module ads_slave_model #(
	parameter int CLKS_PER_HALF_BIT = 4,
	parameter int CLK_NS            = 20
) (
	input  logic i_sclk,
	input  logic i_mosi,
	output logic o_miso,
	input  logic i_csn,
	input  logic i_resetn,
	input  logic i_start,
	output logic o_drdy
);

	// two frames worth of sclk time between drdy pulses
	localparam int DRDY_NS = 2 * ads_dev_pkg::FRAME_BYTES * 16 * CLKS_PER_HALF_BIT * CLK_NS;

	logic [7:0]  regs [0:11];
	logic [7:0]  byte_log [$];   // every non-frame byte seen on mosi
	logic [71:0] frames [$];     // frames handed out, read by the testbench
	int          reset_pulses;
	int          drdy_pulses;    // all drdy pulses, with or without a frame
	logic        rdatac;
	logic [71:0] frame_bits;     // frame being shifted out on miso
	int          frame_left;     // frame bytes still owed
	logic [95:0] rnd;
	logic [7:0]  rx;
	logic [7:0]  tx;
	int          bit_cnt;
	int          phase;          // 0 opcode, 1 count, 2 data
	logic        is_wreg;
	logic        rreg_pend;
	logic [4:0]  cur_addr;

	function automatic logic [7:0] reg_default(input int idx);
		case (idx)
			0:       return 8'h73; // id
			1:       return 8'h02; // config1
			2:       return 8'h80; // config2
			3:       return 8'h10; // loff
			9:       return 8'h02; // resp1
			10:      return 8'h07; // resp2
			default: return 8'h00;
		endcase
	endfunction

	task automatic load_defaults();
		for (int i = 0; i < 12; i++)
			regs[i] = reg_default(i);
	endtask

	// ==================================================================
	// byte decoder, called once per received byte
	// ==================================================================
	task automatic take_byte(input logic [7:0] b);
		if (frame_left > 0) begin
			frame_left--; // dummy clocked during a frame
		end else begin
			byte_log.push_back(b);
			case (phase)
				0: begin
					if (b[7:5] == ads_dev_pkg::op_wreg || b[7:5] == ads_dev_pkg::op_rreg) begin
						is_wreg  = (b[7:5] == ads_dev_pkg::op_wreg);
						cur_addr = b[4:0];
						phase    = 1;
					end else if (b == ads_dev_pkg::cmd_rdatac) begin
						rdatac = 1'b1;
					end else if (b == ads_dev_pkg::cmd_sdatac) begin
						rdatac = 1'b0;
					end
				end
				1: begin
					phase     = 2;        // count byte, always 0 here
					rreg_pend = !is_wreg;
				end
				default: begin
					if (is_wreg && cur_addr < 12)
						regs[cur_addr] = b;
					rreg_pend = 1'b0;
					phase     = 0;
				end
			endcase
		end
	endtask

	initial begin
		load_defaults();
		reset_pulses = 0;
		drdy_pulses  = 0;
		rdatac       = 1'b0;
		frame_left   = 0;
		frame_bits   = '0;
		bit_cnt      = 0;
		phase        = 0;
		is_wreg      = 1'b0;
		rreg_pend    = 1'b0;
		cur_addr     = '0;
		tx           = '0;
		rx           = '0;
		o_miso       = 1'b0;
		o_drdy       = 1'b1;
	end

	always @(negedge i_resetn) begin
		reset_pulses++;
		load_defaults();
		rdatac    = 1'b0;
		phase     = 0;
		rreg_pend = 1'b0;
	end

	always @(i_csn)
		bit_cnt = 0; // realign bytes on every cs change

	// mode 1, shift out on rising sclk
	always @(posedge i_sclk) begin
		if (!i_csn) begin
			if (bit_cnt == 0) begin
				if (frame_left > 0) begin
					tx         = frame_bits[71:64];
					frame_bits = frame_bits << 8;
				end else if (rreg_pend) begin
					tx = regs[cur_addr]; // rreg reply byte
				end else begin
					tx = 8'h00;
				end
			end
			o_miso = tx[7];
			tx     = tx << 1;
		end
	end

	// sample mosi on falling sclk
	always @(negedge i_sclk) begin
		if (!i_csn) begin
			rx = {rx[6:0], i_mosi};
			bit_cnt++;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				take_byte(rx);
			end
		end
	end

	// ==================================================================
	// drdy generator, runs while START is high
	// a random frame is loaded only in continuous read mode
	// ==================================================================
	always begin
		wait (i_start);
		#(DRDY_NS - CLK_NS / 4); // drdy edges a quarter clock before a clk edge
		if (i_start && frame_left == 0) begin
			if (rdatac) begin
				rnd        = {$urandom, $urandom, $urandom};
				frame_bits = rnd[71:0];
				frame_left = ads_dev_pkg::FRAME_BYTES;
				frames.push_back(rnd[71:0]);
			end
			drdy_pulses++;
			o_drdy = 1'b0;
			#(4 * CLK_NS);
			o_drdy = 1'b1;
		end
		#(CLK_NS / 4);
	end

endmodule

/* testbench/tb_ads_ctrl.sv */
`timescale 1ns/1ps

module tb_ads_ctrl;

	localparam int CPHB     = 2;
	localparam int POR      = 20;
	localparam int RST      = 8;
	localparam int CSH      = 4;
	localparam int CLK_NS   = 20;
	localparam int OP_CYC   = 3 * 16 * CPHB + CSH + 20;   // worst single op
	localparam int DRDY_CYC = 2 * ads_dev_pkg::FRAME_BYTES * 16 * CPHB;
	localparam int LIMIT_NS = (10 + POR + RST + 40 * OP_CYC + 12 * DRDY_CYC) * CLK_NS + 20000;

	logic        clk;
	logic        rstn;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [31:0] wb_wdat;
	logic [31:0] wb_rdat;
	logic        wb_ack;
	logic        frame_valid;
	logic        sclk;
	logic        mosi;
	logic        miso;
	logic        csn;
	logic        drdy;
	logic        ads_resetn;
	logic        ads_start;

	int          errors;
	int          checks;
	int          test_err0;
	logic [31:0] rd;
	logic [31:0] cnt0;
	logic [71:0] exp_frame;
	logic [4:0]  addr;
	logic [7:0]  data;
	int          log_n;
	int          pulses0;

	ads_ctrl_top #(
		.CLKS_PER_HALF_BIT (CPHB),
		.POR_CYCLES        (POR),
		.RST_CYCLES        (RST),
		.CS_HOLD_CYCLES    (CSH)
	) uut (
		.i_CLK (clk), .i_RSTN (rstn),
		.i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we), .i_wb_adr (wb_adr),
		.i_wb_dat (wb_wdat), .o_wb_dat (wb_rdat), .o_wb_ack (wb_ack),
		.o_frame_valid (frame_valid),
		.o_SPI_CLK (sclk), .o_SPI_MOSI (mosi), .i_SPI_MISO (miso), .o_SPI_CSN (csn),
		.i_ADS_DRDY (drdy), .o_ADS_RESETN (ads_resetn), .o_ADS_START (ads_start)
	);

	ads_slave_model #(.CLKS_PER_HALF_BIT(CPHB), .CLK_NS(CLK_NS)) u_model (
		.i_sclk (sclk), .i_mosi (mosi), .o_miso (miso), .i_csn (csn),
		.i_resetn (ads_resetn), .i_start (ads_start), .o_drdy (drdy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// watchdog, sized from the worst case of all tests
	initial begin
		#(LIMIT_NS);
		$display("watchdog expired, the run did not finish in time");
		$display("Finished with errors");
		$finish;
	end

	task automatic compare_values(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s finished, %0d errors", name, errors - test_err0);
		test_err0 = errors;
	endtask

	function automatic logic [31:0] op_word(input ads_dev_pkg::host_op_e op,
		input logic [7:0] arg, input logic [7:0] dat);
		return {13'd0, op, arg, dat};
	endfunction

	// ==================================================================
	// wishbone classic cycles, each waits for ack
	// ==================================================================
	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		@(posedge clk);
		wb_cyc  <= 1'b1;
		wb_stb  <= 1'b1;
		wb_we   <= we;
		wb_adr  <= adr;
		wb_wdat <= wdat;
		do
			@(posedge clk);
		while (!wb_ack);
		rdat = wb_rdat;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic run_op(input ads_dev_pkg::host_op_e op, input logic [7:0] arg,
		input logic [7:0] dat);
		logic [31:0] dummy;
		wb_access(1'b1, ads_dev_pkg::addr_op, op_word(op, arg, dat), dummy);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdat);
		wb_access(1'b0, adr, 32'd0, rdat);
	endtask

	task automatic wait_frame();
		do
			@(posedge clk);
		while (!frame_valid);
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		test_err0 = 0;
		log_n     = $urandom(32'h042c_718b); // seed the whole run once
		rstn    <= 1'b0;
		wb_cyc  <= 1'b0;
		wb_stb  <= 1'b0;
		wb_we   <= 1'b0;
		wb_adr  <= '0;
		wb_wdat <= '0;
		repeat (10) @(posedge clk);
		rstn <= 1'b1;

		// init, first op is queued until init done
		run_op(ads_dev_pkg::host_syscmd, ads_dev_pkg::cmd_stop, 8'h00);
		wb_read(ads_dev_pkg::addr_status, rd);
		compare_values("init done bit", {31'd0, rd[31]}, 32'd1);
		compare_values("reset pulses", u_model.reset_pulses, 32'd1);
		compare_values("bytes after init", u_model.byte_log.size(), 32'd1);
		compare_values("init byte", {24'd0, u_model.byte_log[0]}, {24'd0, ads_dev_pkg::cmd_sdatac});
		end_test("init");

		for (int i = 0; i < 4; i++) begin
			addr = 5'(1 + ($urandom % 11));
			data = 8'($urandom);
			run_op(ads_dev_pkg::host_wreg, {3'd0, addr}, data);
			compare_values("model register", {24'd0, u_model.regs[addr]}, {24'd0, data});
			run_op(ads_dev_pkg::host_rreg, {3'd0, addr}, 8'h00);
			wb_read(ads_dev_pkg::addr_rreg_data, rd);
			compare_values("rreg data", rd, {24'd0, data});
		end
		end_test("wreg_rreg");

		// start/stop are pin only
		log_n = u_model.byte_log.size();
		run_op(ads_dev_pkg::host_syscmd, ads_dev_pkg::cmd_start, 8'h00);
		compare_values("start pin high", {31'd0, ads_start}, 32'd1);
		run_op(ads_dev_pkg::host_syscmd, ads_dev_pkg::cmd_stop, 8'h00);
		compare_values("start pin low", {31'd0, ads_start}, 32'd0);
		compare_values("no spi for start/stop", u_model.byte_log.size(), log_n);
		run_op(ads_dev_pkg::host_syscmd, ads_dev_pkg::cmd_wakeup, 8'h00);
		compare_values("wakeup byte", {24'd0, u_model.byte_log[$]}, 32'h02);
		run_op(ads_dev_pkg::host_syscmd, ads_dev_pkg::cmd_standby, 8'h00);
		compare_values("standby byte", {24'd0, u_model.byte_log[$]}, 32'h04);
		compare_values("bytes for wakeup/standby", u_model.byte_log.size(), log_n + 2);
		end_test("syscmd");

		// ==============================================================
		// continuous read
		// ==============================================================
		run_op(ads_dev_pkg::host_syscmd, ads_dev_pkg::cmd_start, 8'h00);
		run_op(ads_dev_pkg::host_rdatac, 8'h00, 8'h00);
		wb_read(ads_dev_pkg::addr_status, cnt0);
		compare_values("streaming bit", {31'd0, cnt0[30]}, 32'd1);
		for (int k = 1; k <= 4; k++) begin
			wait_frame();
			if (u_model.frames.size() == 0) begin
				errors++;
				$display("frame valid at %0t ns with no frame sent by the model", $time);
				exp_frame = '0;
			end else begin
				exp_frame = u_model.frames.pop_front();
			end
			wb_read(ads_dev_pkg::addr_frame_stat, rd);
			compare_values("frame stat", rd, {8'd0, exp_frame[71:48]});
			wb_read(ads_dev_pkg::addr_frame_ch1, rd);
			compare_values("frame ch1", rd, {8'd0, exp_frame[47:24]});
			wb_read(ads_dev_pkg::addr_frame_ch2, rd);
			compare_values("frame ch2", rd, {8'd0, exp_frame[23:0]});
			wb_read(ads_dev_pkg::addr_status, rd);
			compare_values("frame count", {16'd0, rd[15:0]}, {16'd0, cnt0[15:0] + 16'(k)});
		end
		end_test("rdatac");

		// stop right after a frame so no drdy lands mid command
		wait_frame();
		run_op(ads_dev_pkg::host_sdatac, 8'h00, 8'h00);
		wb_read(ads_dev_pkg::addr_status, cnt0);
		compare_values("streaming off", {31'd0, cnt0[30]}, 32'd0);
		compare_values("start bit off", {31'd0, cnt0[29]}, 32'd0);
		compare_values("start pin off", {31'd0, ads_start}, 32'd0);
		compare_values("sdatac byte", {24'd0, u_model.byte_log[$]}, 32'h11);
		// START again, drdy keeps pulsing but the reader stays off
		run_op(ads_dev_pkg::host_syscmd, ads_dev_pkg::cmd_start, 8'h00);
		pulses0 = u_model.drdy_pulses;
		repeat (3 * DRDY_CYC) @(posedge clk);
		compare_values("drdy pulses while stopped",
			{31'd0, (u_model.drdy_pulses - pulses0) >= 2}, 32'd1);
		wb_read(ads_dev_pkg::addr_status, rd);
		compare_values("frame count frozen", {16'd0, rd[15:0]}, {16'd0, cnt0[15:0]});
		end_test("sdatac");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
